/* design/dmix_pkg.sv */
`default_nettype none

package dmix_pkg;

    // mix geometry
    localparam int NUM_CH    = 2;                // channel sources summed
    localparam int SAMPLE_W  = 24;               // signed pcm word
    localparam int GAIN_W    = 16;               // unsigned gain, 8.8 fixed point
    localparam int GAIN_FRAC = 8;
    localparam logic [GAIN_W-1:0] GAIN_UNITY = 16'h0100;

    // arithmetic widths, the gain gets a zero sign bit before the multiply
    localparam int MUL_W    = SAMPLE_W + GAIN_W + 1;
    localparam int SCALED_W = MUL_W - GAIN_FRAC;            // product after >>> 8
    localparam int SUM_W    = SCALED_W + $clog2(NUM_CH) + 1; // headroom for the channel sum

    // i2s frame, all counts in master clocks
    localparam int CLK_PER_BCK  = 4;
    localparam int BCK_PER_SLOT = 32;
    localparam int SLOT_CLKS    = CLK_PER_BCK * BCK_PER_SLOT; // 128
    localparam int FRAME_CLKS   = 2 * SLOT_CLKS;              // 256, must be a power of two
    localparam int POP_LEAD     = 16;                         // pop this early before a slot
    localparam int CNT_W        = $clog2(FRAME_CLKS);
    localparam int PHASE_W      = $clog2(CLK_PER_BCK);        // clock phase within one bck
    localparam int SLOT_W       = $clog2(SLOT_CLKS);          // position within one slot

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_t;

    // one-hot side strobe, bit 0 left, bit 1 right
    typedef logic [1:0] side_t;

    localparam side_t SIDE_NONE = 2'b00;
    localparam side_t SIDE_L    = 2'b01;
    localparam side_t SIDE_R    = 2'b10;

endpackage

`default_nettype wire

/* design/dmix_cfg_pkg.sv */
`default_nettype none

package dmix_cfg_pkg;

    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 32;

    // 0 .. NUM_CH-1 are channel gains, then the control word
    localparam logic [CFG_ADDR_W-1:0] ADDR_CTRL = CFG_ADDR_W'(dmix_pkg::NUM_CH);

    typedef logic [dmix_pkg::GAIN_W-1:0] gain_t;

    typedef struct packed {
        logic                  we;
        logic [CFG_ADDR_W-1:0] addr;
        logic [CFG_DATA_W-1:0] data;
    } cfg_wr_t;

    // gain view, left gain sits in the low half
    typedef struct packed {
        gain_t gain_r;
        gain_t gain_l;
    } gain_view_t;

    // control view, mute bit n belongs to channel n
    typedef struct packed {
        logic [CFG_DATA_W-dmix_pkg::NUM_CH-2:0] rsvd;
        logic                                   clear_underrun;
        logic [dmix_pkg::NUM_CH-1:0]            mute;
    } ctrl_view_t;

    typedef union packed {
        gain_view_t gain;
        ctrl_view_t ctrl;
    } cfg_word_u;

    typedef struct packed {
        gain_t gain_l;
        gain_t gain_r;
        logic  mute;
    } chan_cfg_t;

    typedef chan_cfg_t [dmix_pkg::NUM_CH-1:0] mix_cfg_t;

endpackage

`default_nettype wire

/* design/dmix_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module dmix_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire dmix_cfg_pkg::cfg_wr_t  cfg_i,
    input  wire logic                   underrun_i,  // one-cycle pulse from the dac driver
    output dmix_cfg_pkg::mix_cfg_t      mix_cfg_o,
    output logic                        led_o
);

    dmix_cfg_pkg::cfg_word_u word;       // same bits, read by address
    logic                    ctrl_wr;
    logic                    underrun_q; // sticky

    assign word    = cfg_i.data;
    assign ctrl_wr = cfg_i.we && (cfg_i.addr == dmix_cfg_pkg::ADDR_CTRL);

    // gains and mute mask
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int ch = 0; ch < dmix_pkg::NUM_CH; ch++) begin
                mix_cfg_o[ch].gain_l <= dmix_pkg::GAIN_UNITY; // unity after reset
                mix_cfg_o[ch].gain_r <= dmix_pkg::GAIN_UNITY;
                mix_cfg_o[ch].mute   <= 1'b0;
            end
        end else begin
            for (int ch = 0; ch < dmix_pkg::NUM_CH; ch++) begin
                // gain address, one per channel
                if (cfg_i.we && cfg_i.addr == dmix_cfg_pkg::CFG_ADDR_W'(ch)) begin
                    mix_cfg_o[ch].gain_l <= word.gain.gain_l;
                    mix_cfg_o[ch].gain_r <= word.gain.gain_r;
                end
                if (ctrl_wr) begin
                    mix_cfg_o[ch].mute <= word.ctrl.mute[ch]; // whole mask rewritten
                end
            end
        end
    end

    // underrun flag, a new underrun wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            underrun_q <= 1'b0;
        end else if (underrun_i) begin
            underrun_q <= 1'b1;
        end else if (ctrl_wr && word.ctrl.clear_underrun) begin
            underrun_q <= 1'b0;
        end
    end

    assign led_o = underrun_q; // lit once any slot went out empty

endmodule

`default_nettype wire

/* design/mixer.sv */
`timescale 1ns/1ps
`default_nettype none

// four stage pipe, pop at t gives ack_o at t+4
//   t+1 pop fanned out to all sources
//   t+2 sources ack, gain applied on the fly
//   t+3 scaled products registered
//   t+4 sum saturated, ack back to the driver
module mixer (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire dmix_cfg_pkg::mix_cfg_t                 cfg_i,
    input  wire dmix_pkg::side_t                        pop_i,
    output dmix_pkg::side_t                             ack_o,
    output dmix_pkg::sample_t                           data_o,
    output dmix_pkg::side_t [dmix_pkg::NUM_CH-1:0]      src_pop_o,
    input  wire dmix_pkg::side_t [dmix_pkg::NUM_CH-1:0] src_ack_i,
    input  wire dmix_pkg::sample_t [dmix_pkg::NUM_CH-1:0] src_data_i
);

    dmix_pkg::side_t pop_q;  // stage 1 tag
    dmix_pkg::side_t tag2_q; // stage 2 tag, the cycle sources answer in
    dmix_pkg::side_t tag3_q; // stage 3 tag, rides with prod_q

    dmix_cfg_pkg::gain_t               gain [dmix_pkg::NUM_CH];
    logic                              hit  [dmix_pkg::NUM_CH]; // acked and not muted
    logic signed [dmix_pkg::MUL_W-1:0] mul  [dmix_pkg::NUM_CH];

    logic signed [dmix_pkg::SCALED_W-1:0] prod_q [dmix_pkg::NUM_CH];
    logic signed [dmix_pkg::SUM_W-1:0]    sum;

    // clip to the 24-bit range, in range when every bit above the sample sign agrees
    function automatic dmix_pkg::sample_t sat(input logic signed [dmix_pkg::SUM_W-1:0] v);
        logic [dmix_pkg::SUM_W-dmix_pkg::SAMPLE_W:0] top;
        top = v[dmix_pkg::SUM_W-1:dmix_pkg::SAMPLE_W-1];
        if (top == {(dmix_pkg::SUM_W-dmix_pkg::SAMPLE_W+1){v[dmix_pkg::SUM_W-1]}}) begin
            return v[dmix_pkg::SAMPLE_W-1:0];
        end
        if (v[dmix_pkg::SUM_W-1]) begin
            return {1'b1, {(dmix_pkg::SAMPLE_W-1){1'b0}}}; // most negative
        end
        return {1'b0, {(dmix_pkg::SAMPLE_W-1){1'b1}}};     // most positive
    endfunction

    // side tag pipe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pop_q  <= dmix_pkg::SIDE_NONE;
            tag2_q <= dmix_pkg::SIDE_NONE;
            tag3_q <= dmix_pkg::SIDE_NONE;
            ack_o  <= dmix_pkg::SIDE_NONE;
        end else begin
            pop_q  <= pop_i;
            tag2_q <= pop_q;
            tag3_q <= tag2_q;
            ack_o  <= tag3_q;
        end
    end

    always_comb begin
        for (int ch = 0; ch < dmix_pkg::NUM_CH; ch++) begin
            src_pop_o[ch] = pop_q; // every source popped together
        end
    end

    // gain by side, zero-extended so the multiply stays signed
    always_comb begin
        for (int ch = 0; ch < dmix_pkg::NUM_CH; ch++) begin
            gain[ch] = tag2_q[1] ? cfg_i[ch].gain_r : cfg_i[ch].gain_l;
            hit[ch]  = |(src_ack_i[ch] & tag2_q) && !cfg_i[ch].mute; // a silent source is 0
            mul[ch]  = $signed(src_data_i[ch]) * $signed({1'b0, gain[ch]});
        end
    end

    // arithmetic >>> GAIN_FRAC by dropping the fraction bits
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < dmix_pkg::NUM_CH; ch++) begin
            if (hit[ch]) begin
                prod_q[ch] <= mul[ch][dmix_pkg::MUL_W-1:dmix_pkg::GAIN_FRAC];
            end else begin
                prod_q[ch] <= '0;
            end
        end
    end

    always_comb begin
        sum = '0;
        for (int ch = 0; ch < dmix_pkg::NUM_CH; ch++) begin
            sum = sum + dmix_pkg::SUM_W'(prod_q[ch]); // sign extended
        end
    end

    always_ff @(posedge clk) begin
        data_o <= sat(sum); // read by the driver only with ack_o
    end

endmodule

`default_nettype wire

/* design/dac_drv.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running i2s master, one frame per FRAME_CLKS
// cnt bit 0 is sck, bit PHASE_W-1 is bck, bit SLOT_W is lrck
module dac_drv (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire dmix_pkg::sample_t data_i,
    input  wire dmix_pkg::side_t   ack_i,
    output dmix_pkg::side_t        pop_o,
    output logic                   underrun_o,
    output logic                   sck_o,
    output logic                   bck_o,
    output logic                   lrck_o,
    output logic                   data_o
);

    logic [dmix_pkg::CNT_W-1:0] cnt_q;
    logic [dmix_pkg::CNT_W-1:0] cnt_nxt;
    logic                       run_q;     // set at the first left slot
    logic                       run_nxt;
    logic                       edge_nxt;  // bck falls entering the next cycle
    logic                       slot_nxt;  // slot starts next cycle
    logic                       side_nxt;  // 0 left, 1 right

    dmix_pkg::side_t   pop_nxt;
    dmix_pkg::side_t   pop_q;
    dmix_pkg::stereo_t hold_q;             // waiting sample per side
    dmix_pkg::side_t   hold_v_q;
    dmix_pkg::side_t   hold_v_nxt;
    logic              next_v;
    dmix_pkg::sample_t next_smp;
    dmix_pkg::sample_t load_smp;
    logic              underrun_q;

    logic [dmix_pkg::SAMPLE_W:0] sh_q;     // extra top bit is the one-bck i2s delay

    assign cnt_nxt  = cnt_q + 1'b1;        // wraps at FRAME_CLKS
    assign run_nxt  = run_q || (cnt_nxt == '0);
    assign edge_nxt = (cnt_nxt[dmix_pkg::PHASE_W-1:0] == '0);
    assign slot_nxt = (cnt_nxt[dmix_pkg::SLOT_W-1:0] == '0);
    assign side_nxt = cnt_nxt[dmix_pkg::SLOT_W];

    // pop the side of the coming slot POP_LEAD clocks early
    always_comb begin
        pop_nxt = dmix_pkg::SIDE_NONE;
        if (cnt_nxt == dmix_pkg::CNT_W'(dmix_pkg::FRAME_CLKS - dmix_pkg::POP_LEAD)) begin
            pop_nxt = dmix_pkg::SIDE_L;    // also in the pre-roll frame
        end else if (run_q &&
                     cnt_nxt == dmix_pkg::CNT_W'(dmix_pkg::SLOT_CLKS - dmix_pkg::POP_LEAD)) begin
            pop_nxt = dmix_pkg::SIDE_R;
        end
    end

    // a new pop drops any stale sample, a slot start consumes it, ack refills it
    always_comb begin
        hold_v_nxt = hold_v_q & ~pop_nxt;
        if (slot_nxt) begin
            hold_v_nxt[side_nxt] = 1'b0;
        end
        hold_v_nxt = hold_v_nxt | ack_i;
    end

    assign next_v   = hold_v_q[side_nxt];
    assign next_smp = side_nxt ? hold_q.r : hold_q.l;
    assign load_smp = (next_v && run_nxt) ? next_smp : '0; // zeros when nothing came

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q      <= '0;
            run_q      <= 1'b0;
            pop_q      <= dmix_pkg::SIDE_NONE;
            hold_v_q   <= dmix_pkg::SIDE_NONE;
            underrun_q <= 1'b0;
            sh_q       <= '0;
        end else begin
            cnt_q      <= cnt_nxt;
            run_q      <= run_nxt;
            pop_q      <= pop_nxt;
            hold_v_q   <= hold_v_nxt;
            underrun_q <= slot_nxt && run_nxt && !next_v; // pulse at slot start
            if (slot_nxt) begin
                sh_q <= {1'b0, load_smp};
            end else if (edge_nxt) begin
                sh_q <= {sh_q[dmix_pkg::SAMPLE_W-1:0], 1'b0}; // msb first, zero fill
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (ack_i[0]) hold_q.l <= data_i;
        if (ack_i[1]) hold_q.r <= data_i;
    end

    assign pop_o      = pop_q;
    assign underrun_o = underrun_q;
    assign sck_o      = cnt_q[0];                          // clk/2, runs from reset
    assign bck_o      = run_q & cnt_q[dmix_pkg::PHASE_W-1]; // held low in pre-roll
    assign lrck_o     = run_q & cnt_q[dmix_pkg::SLOT_W];    // low = left slot
    assign data_o     = sh_q[dmix_pkg::SAMPLE_W];

endmodule

`default_nettype wire

/* design/dmix_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dmix_top (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,

    input  wire dmix_cfg_pkg::cfg_wr_t                  cfg_i,

    // channel sources, answered one clock after pop
    output dmix_pkg::side_t [dmix_pkg::NUM_CH-1:0]      src_pop_o,
    input  wire dmix_pkg::side_t [dmix_pkg::NUM_CH-1:0] src_ack_i,
    input  wire dmix_pkg::sample_t [dmix_pkg::NUM_CH-1:0] src_data_i,

    // i2s to dac
    output logic                                        dac_sck_o,
    output logic                                        dac_bck_o,
    output logic                                        dac_lrck_o,
    output logic                                        dac_data_o,

    output logic                                        led_o  // sticky underrun
);

    dmix_cfg_pkg::mix_cfg_t mix_cfg;
    dmix_pkg::side_t        mix_pop;   // driver -> mixer
    dmix_pkg::side_t        mix_ack;   // mixer -> driver, 4 clocks later
    dmix_pkg::sample_t      mix_data;
    logic                   underrun;

    dmix_regs regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .cfg_i      (cfg_i),
        .underrun_i (underrun),
        .mix_cfg_o  (mix_cfg),
        .led_o      (led_o)
    );

    mixer mixer (
        .clk        (clk),
        .reset_i    (reset_i),
        .cfg_i      (mix_cfg),
        .pop_i      (mix_pop),
        .ack_o      (mix_ack),
        .data_o     (mix_data),
        .src_pop_o  (src_pop_o),
        .src_ack_i  (src_ack_i),
        .src_data_i (src_data_i)
    );

    dac_drv dac (
        .clk        (clk),
        .reset_i    (reset_i),
        .data_i     (mix_data),
        .ack_i      (mix_ack),
        .pop_o      (mix_pop),
        .underrun_o (underrun),
        .sck_o      (dac_sck_o),
        .bck_o      (dac_bck_o),
        .lrck_o     (dac_lrck_o),
        .data_o     (dac_data_o)
    );

endmodule

`default_nettype wire

/* tests/dmix_props.sv */
`timescale 1ns/1ps
`default_nettype none

// handshake and i2s timing checks, bound into the mixer and the dac driver
module dmix_props #(
    parameter bit DRV = 1'b0                // set when bound into dac_drv
) (
    input wire logic            clk,
    input wire logic            reset_i,
    input wire dmix_pkg::side_t pop_i,
    input wire dmix_pkg::side_t ack_i,
    input wire logic            underrun_i,
    input wire logic            bck_i,
    input wire logic            lrck_i
);

    logic [3:0] age_q;                      // clocks since reset, saturating
    logic       settled;                    // enough history for $past

    always_ff @(posedge clk) begin
        if (reset_i) begin
            age_q <= '0;
        end else if (age_q != 4'hf) begin
            age_q <= age_q + 1'b1;
        end
    end

    assign settled = (age_q == 4'hf);

    assert property (@(posedge clk) disable iff (reset_i || !settled)
        $onehot0(pop_i) && $onehot0(ack_i))
        else $error("pop or ack strobe with both sides set");

    if (DRV) begin : g_drv
        // word clock moves together with a falling bit clock
        assert property (@(posedge clk) disable iff (reset_i || !settled)
            (lrck_i != $past(lrck_i)) |-> (!bck_i && $past(bck_i)))
            else $error("lrck changed away from a falling bck edge");
        // slot start is 12 clocks after the ack of its pop
        assert property (@(posedge clk) disable iff (reset_i || !settled)
            underrun_i |-> ($past(ack_i, 12) == dmix_pkg::SIDE_NONE))
            else $error("underrun although the mixer answered the pop");
    end else begin : g_mix
        assert property (@(posedge clk) disable iff (reset_i || !settled)
            ack_i == $past(pop_i, 4))
            else $error("mixer ack does not follow its pop by 4 clocks");
    end

endmodule

bind mixer dmix_props #(.DRV(1'b0)) mix_props (
    .clk        (clk),
    .reset_i    (reset_i),
    .pop_i      (pop_i),
    .ack_i      (ack_o),
    .underrun_i (1'b0),
    .bck_i      (1'b0),
    .lrck_i     (1'b0)
);

bind dac_drv dmix_props #(.DRV(1'b1)) drv_props (
    .clk        (clk),
    .reset_i    (reset_i),
    .pop_i      (pop_o),
    .ack_i      (ack_i),
    .underrun_i (underrun_o),
    .bck_i      (bck_o),
    .lrck_i     (lrck_o)
);

`default_nettype wire

/* tests/dmix_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmix_tb;

    localparam int CLK_NS     = 10;
    localparam int NUM_CH     = dmix_pkg::NUM_CH;
    localparam int NUM_RANDOM = 4;
    localparam int NUM_ROWS   = 11 + NUM_RANDOM;
    localparam longint WATCHDOG_NS = longint'(NUM_ROWS * 3 + 4) * dmix_pkg::FRAME_CLKS * CLK_NS;

    typedef struct packed {
        logic [NUM_CH-1:0][15:0] gain_l;
        logic [NUM_CH-1:0][15:0] gain_r;
        logic [NUM_CH-1:0]       mute;
        logic [NUM_CH-1:0]       silent;  // source never acks
        logic                    drop_l;  // mixer misses the left pop, underrun
        logic                    clr;     // clear_underrun in the control write
        logic                    rnd;
        logic [NUM_CH-1:0][23:0] smp_l;
        logic [NUM_CH-1:0][23:0] smp_r;
    } row_t;

    logic                                clk;
    logic                                reset;
    dmix_cfg_pkg::cfg_wr_t               cfg;
    dmix_pkg::side_t   [NUM_CH-1:0]      src_pop;
    dmix_pkg::side_t   [NUM_CH-1:0]      src_ack;
    dmix_pkg::sample_t [NUM_CH-1:0]      src_data;
    dmix_pkg::side_t   [NUM_CH-1:0]      pop_seen; // pops seen in the last cycle
    logic dac_sck, dac_bck, dac_lrck, dac_data, led;

    row_t rows_q[$];
    row_t cur;                             // row the sources answer from
    int   errors = 0;
    int   checks = 0;

    dmix_top dut_i (
        .clk(clk), .reset_i(reset), .cfg_i(cfg),
        .src_pop_o(src_pop), .src_ack_i(src_ack), .src_data_i(src_data),
        .dac_sck_o(dac_sck), .dac_bck_o(dac_bck), .dac_lrck_o(dac_lrck),
        .dac_data_o(dac_data), .led_o(led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(negedge clk) pop_seen = src_pop;

    // source models, ack one clock after the pop with data from the row
    initial begin
        src_ack  = '0;
        src_data = '0;
        forever begin
            @(posedge clk);
            #1;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                src_ack[ch]  = cur.silent[ch] ? dmix_pkg::SIDE_NONE : pop_seen[ch];
                src_data[ch] = pop_seen[ch][1] ? cur.smp_r[ch] : cur.smp_l[ch];
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the frame captures did not finish in time");
        $display("Test failed");
        $finish;
    end

    task automatic add_row(input logic [15:0] g0l, g0r, g1l, g1r, input logic [1:0] mute,
                           silent, input logic drop_l, clr, input logic [23:0] s0l, s0r,
                           s1l, s1r);
        row_t r;
        r        = '0;
        r.gain_l = {g1l, g0l};
        r.gain_r = {g1r, g0r};
        r.mute   = mute;
        r.silent = silent;
        r.drop_l = drop_l;
        r.clr    = clr;
        r.smp_l  = {s1l, s0l};
        r.smp_r  = {s1r, s0r};
        rows_q.push_back(r);
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        cfg.we   = 1'b1;
        cfg.addr = addr;
        cfg.data = data;
        @(posedge clk);
        #1;
        cfg.we   = 1'b0;
    endtask

    task automatic apply_config(input row_t r);
        dmix_cfg_pkg::cfg_word_u w;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            w             = '0;
            w.gain.gain_l = r.gain_l[ch];
            w.gain.gain_r = r.gain_r[ch];
            cfg_write(dmix_cfg_pkg::CFG_ADDR_W'(ch), w);
        end
        w                     = '0;
        w.ctrl.mute           = r.mute;
        w.ctrl.clear_underrun = r.clr;
        cfg_write(dmix_cfg_pkg::ADDR_CTRL, w);
    endtask

    // gain product floored by 8 fraction bits, summed, clipped to 24 bits
    function automatic logic [23:0] expect_mix(input row_t r, input bit right);
        longint acc;
        longint smp;
        longint gain;
        acc = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            smp  = right ? longint'(signed'(r.smp_r[ch])) : longint'(signed'(r.smp_l[ch]));
            gain = right ? longint'(r.gain_r[ch]) : longint'(r.gain_l[ch]);
            if (!r.mute[ch] && !r.silent[ch]) acc = acc + ((smp * gain) >>> 8);
        end
        if (acc > 64'sd8388607) return 24'h7fffff;
        if (acc < -64'sd8388608) return 24'h800000;
        return acc[23:0];
    endfunction

    // sck at half the master clock, flips between every two falling clk edges
    task automatic check_sck(input int idx);
        logic prev;
        @(negedge clk);
        prev = dac_sck;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            checks++;
            if (dac_sck !== ~prev) begin
                $display("ERROR test %0d dac_sck_o: expected %h got %h", idx, ~prev, dac_sck);
                errors++;
            end
            prev = dac_sck;
        end
    endtask

    // one frame from the lrck fall, 32 bck per slot
    task automatic capture_frame(output logic [31:0] word_l, word_r,
                                 output logic [63:0] lr_bits);
        for (int b = 0; b < 64; b++) begin
            @(posedge dac_bck);
            lr_bits = {lr_bits[62:0], dac_lrck};
            if (b < 32) word_l = {word_l[30:0], dac_data};
            else        word_r = {word_r[30:0], dac_data};
        end
    endtask

    initial begin
        int          errs_before;
        row_t        r;
        logic [31:0] got_l, got_r, exp_l, exp_r;
        logic [63:0] got_lr, exp_lr;
        logic        led_exp;
        void'($urandom(32'h1e5b));
        reset   = 1'b1;
        cfg     = '0;
        cur     = '0;
        led_exp = 1'b0;
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b00, 0, 0,   // unity
                24'h001000, 24'hfff800, 24'h000234, 24'h010000);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b00, 0, 0,   // sum clips
                24'h600000, 24'ha00000, 24'h300000, 24'hc00000);
        add_row(16'h080, 16'h200, 16'h200, 16'h080, 2'b00, 2'b00, 0, 0,   // half and double
                24'hfffffd, 24'h000123, 24'h000101, 24'h0abcde);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b10, 2'b00, 0, 0,   // ch1 muted
                24'h012345, 24'hfedcba, 24'h111111, 24'h222222);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b00, 0, 0,
                24'h012345, 24'hfedcba, 24'h111111, 24'h222222);
        add_row(16'h400, 16'h400, 16'h400, 16'h400, 2'b00, 2'b00, 0, 0,   // high gain clips
                24'h300000, 24'hd00000, 24'h200000, 24'he00000);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b01, 0, 0,   // ch0 never acks
                24'h012345, 24'hfedcba, 24'h111111, 24'h222222);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b11, 0, 0,
                24'h012345, 24'hfedcba, 24'h111111, 24'h222222);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b00, 1, 0,   // forced underrun
                24'h001000, 24'hfff800, 24'h000234, 24'h010000);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b00, 0, 0,   // led holds
                24'h012345, 24'hfedcba, 24'h111111, 24'h222222);
        add_row(16'h100, 16'h100, 16'h100, 16'h100, 2'b00, 2'b00, 0, 1,   // led cleared
                24'h012345, 24'hfedcba, 24'h111111, 24'h222222);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            add_row(0, 0, 0, 0, 2'b00, 2'b00, 0, 0, 0, 0, 0, 0);
            rows_q[rows_q.size() - 1].rnd = 1'b1;
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < rows_q.size(); i++) begin
            r = rows_q[i];
            if (r.rnd) begin
                for (int ch = 0; ch < NUM_CH; ch++) begin
                    r.gain_l[ch] = 16'($urandom_range(0, 16'h3ff));
                    r.gain_r[ch] = 16'($urandom_range(0, 16'h3ff));
                    r.smp_l[ch]  = 24'($urandom);
                    r.smp_r[ch]  = 24'($urandom);
                end
            end
            errs_before = errors;
            cur = r;                                  // sources switch before the write
            apply_config(r);
            if (r.clr) led_exp = 1'b0;
            @(negedge dac_lrck);                      // frame now running had early pops
            check_sck(i);
            if (r.drop_l) begin
                @(posedge dac_lrck);
                force dut_i.mix_pop = dmix_pkg::SIDE_NONE; // left pop never reaches mixer
            end
            @(negedge dac_lrck);
            if (r.drop_l) begin
                release dut_i.mix_pop;
                led_exp = 1'b1;
            end
            capture_frame(got_l, got_r, got_lr);
            exp_l  = r.drop_l ? 32'h0 : {1'b0, expect_mix(r, 1'b0), 7'b0};
            exp_r  = {1'b0, expect_mix(r, 1'b1), 7'b0};   // one bck delay, zero tail
            exp_lr = {32'h0, 32'hffffffff};              // low for left, high for right
            checks = checks + 4;
            if (got_l !== exp_l) begin
                $display("ERROR test %0d dac_data_o left slot: expected %h got %h",
                         i, exp_l, got_l);
                errors++;
            end
            if (got_r !== exp_r) begin
                $display("ERROR test %0d dac_data_o right slot: expected %h got %h",
                         i, exp_r, got_r);
                errors++;
            end
            if (got_lr !== exp_lr) begin
                $display("ERROR test %0d dac_lrck_o: expected %h got %h", i, exp_lr, got_lr);
                errors++;
            end
            if (led !== led_exp) begin
                $display("ERROR test %0d led_o: expected %h got %h", i, led_exp, led);
                errors++;
            end
            $display("test %0d: %s", i, (errors == errs_before) ? "ok" : "mismatch");
        end
        $display("%0d tests, %0d checks, %0d errors", rows_q.size(), checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/dmix_pkg.sv
design/dmix_cfg_pkg.sv
design/dmix_regs.sv
design/mixer.sv
design/dac_drv.sv
design/dmix_top.sv
tests/dmix_props.sv
tests/dmix_tb.sv

/* run.sh */
#!/bin/sh
# build and run the mixer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dmix_tb -f project.f -o dmix_sim

out=$(./obj_dir/dmix_sim) || true
printf '%s\n' "$out"

# the script fails unless the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "Test passed"
